// File: filelist.f
logic/ship_pkg.sv
logic/switch_debouncer.sv
logic/pulse_timer.sv
logic/telemetry_regs.sv
logic/ship_command.sv
logic/status_display.sv
logic/ship_console.sv
tests/ship_console_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ship console testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module ship_console_tb -o ship_console_sim \
	&& ./obj_dir/ship_console_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tests/ship_console_tb.sv
`timescale 1ns/1ps

module ship_console_tb;

	import ship_pkg::*;

	localparam int DEBOUNCE_CYCLES = 4;
	localparam int PAGE_PERIOD = 20;
	localparam int CLK_PERIOD = 8;
	localparam int SETTLE_CYCLES = DEBOUNCE_CYCLES + 6;	// Synchronizer, filter, command flop
	localparam int APB_CYCLES = 50 * 3;			// About fifty transfers of three cycles
	localparam int RUN_CYCLES = 16 * SETTLE_CYCLES + APB_CYCLES + 14 * PAGE_PERIOD;
	localparam int LIMIT_CYCLES = RUN_CYCLES + 200;

	logic system_clk;
	logic rst_n;
	logic [17:0] sw;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic [7:0][6:0] hex;
	logic [17:0] ledr;
	logic [8:0] ledg;

	int value_errors;
	int protocol_errors;
	int seed;
	logic [31:0] power_words [4];	// Last written, kept bits only
	logic [3:0] sensor_code;
	logic [15:0] x_pos;
	logic [15:0] y_pos;
	logic [15:0] rx_sum;

	// Active low glyphs, bit 0 is segment a
	logic [6:0] seg_font [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

	ship_console #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.PAGE_PERIOD(PAGE_PERIOD)
	) DUT (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.sw(sw),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.hex(hex),
		.ledr(ledr),
		.ledg(ledg)
	);

	always #(CLK_PERIOD / 2) system_clk = ~system_clk;

	function automatic logic [3:0] segments_to_nibble(input logic [6:0] seg);
		logic [3:0] nib;
		logic found;
		nib = 4'h0;
		found = 1'b0;
		for (int i = 0; i < 16; i++)
		begin
			if (seg_font[i] == seg)
			begin
				nib = 4'(i);
				found = 1'b1;
			end
		end
		if (!found)
		begin
			$display("Digit pattern %b is not a hex glyph", seg);
			protocol_errors++;
		end
		return nib;
	endfunction

	// hex0 is the lowest nibble
	function automatic logic [31:0] shown_digits();
		logic [31:0] word;
		for (int i = 0; i < 8; i++)
			word[4*i +: 4] = segments_to_nibble(hex[i]);
		return word;
	endfunction

	function automatic logic [63:0] expected_cmd(input logic [17:0] s);
		logic [23:0] hookup;
		logic [1:0] eng_dir;
		logic [1:0] sen_dir;
		logic [7:0] step;
		logic [9:0] power;
		for (int i = 0; i < 8; i++)
			hookup[3*i +: 3] = 3'(i);		// Slot i takes crystal i
		eng_dir = !s[SW_DIR_EN] ? MOVE_NONE : (s[SW_DIR_RIGHT] ? MOVE_RIGHT : MOVE_LEFT);
		sen_dir = !s[SW_SENSOR_EN] ? MOVE_NONE : (s[SW_SENSOR_RIGHT] ? MOVE_RIGHT : MOVE_LEFT);
		step = s[SW_SENSOR_FAST] ? 8'd2 : 8'd1;
		power = s[SW_POWER_HIGH] ? 10'd20 : 10'd10;
		return {hookup, s[SW_ENGINE], eng_dir, sen_dir, step, s[SW_FIRE], power, TX_CHECKSUM};
	endfunction

	function automatic logic [3:0] pair_power(input int p);
		return power_words[p / 8][4 * (p % 8) +: 4];
	endfunction

	// Display words as {hex7..hex4, hex3..hex0}
	function automatic logic [31:0] expected_page(input int p);
		int base;
		base = 4 * (p - 1);
		if (p == 0)
			return {16'hDCBA, 16'hABCD};
		if (p == 8)
			return {rx_sum, rx_sum};
		return {4'h0, pair_power(base + 2), 4'h0, pair_power(base + 3),
			4'h0, pair_power(base), 4'h0, pair_power(base + 1)};
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("** Error [%s]: expected %h, actual %h", test, expected, actual);
		value_errors++;
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge system_clk);
		#1;
		apb_req.paddr = addr;
		apb_req.pwrite = write;
		apb_req.pwdata = wdata;
		apb_req.psel = 1'b1;			// Setup phase
		apb_req.penable = 1'b0;
		@(posedge system_clk);
		#1;
		apb_req.penable = 1'b1;			// Access phase
		@(negedge system_clk);
		waits = 0;
		while (!apb_rsp.pready && waits < 8)
		begin
			@(negedge system_clk);
			waits++;
		end
		if (!apb_rsp.pready)
		begin
			$display("APB slave never raised pready at address %h", addr);
			protocol_errors++;
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge system_clk);
		#1;
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic apb_write(input string test, input logic [7:0] addr, input logic [31:0] data,
		input logic expect_err);
		logic [31:0] unused_rd;
		logic err;
		apb_transfer(1'b1, addr, data, unused_rd, err);
		if (err !== expect_err)
			report_mismatch(test, 64'(expect_err), 64'(err));
	endtask

	task automatic apb_read(input string test, input logic [7:0] addr, output logic [31:0] data,
		input logic expect_err);
		logic err;
		apb_transfer(1'b0, addr, 32'h0, data, err);
		if (err !== expect_err)
			report_mismatch(test, 64'(expect_err), 64'(err));
	endtask

	task automatic read_cmd(input string test, output logic [63:0] rec);
		logic [31:0] lo;
		logic [31:0] hi;
		apb_read(test, REG_CMD_LO, lo, 1'b0);
		apb_read(test, REG_CMD_HI, hi, 1'b0);
		rec = {hi, lo};
	endtask

	task automatic set_switches(input logic [17:0] value);
		@(posedge system_clk);
		#1;
		sw = value;
		repeat (SETTLE_CYCLES) @(posedge system_clk);	// Past the filter
	endtask

	// Returns the negedges counted until ledg[6] changes
	task automatic wait_heartbeat(output int cycles);
		logic start;
		@(negedge system_clk);
		start = ledg[6];
		cycles = 0;
		while (ledg[6] == start && cycles <= 2 * PAGE_PERIOD)
		begin
			@(negedge system_clk);
			cycles++;
		end
		if (ledg[6] == start)
		begin
			$display("Heartbeat on ledg[6] stopped toggling");
			protocol_errors++;
		end
	endtask

	task automatic verify_telemetry(input string test);
		logic [31:0] data;
		for (int w = 0; w < 4; w++)
		begin
			apb_read(test, REG_POWER0 + 8'(4 * w), data, 1'b0);
			if (data !== power_words[w])
				report_mismatch(test, 64'(power_words[w]), 64'(data));
		end
		apb_read(test, REG_SENSOR, data, 1'b0);
		if (data !== {28'h0, sensor_code})
			report_mismatch(test, 64'(sensor_code), 64'(data));
		apb_read(test, REG_POSITION, data, 1'b0);
		if (data !== {y_pos, x_pos})
			report_mismatch(test, 64'({y_pos, x_pos}), 64'(data));
		apb_read(test, REG_RX_CHECKSUM, data, 1'b0);
		if (data !== {16'h0000, rx_sum})
			report_mismatch(test, 64'(rx_sum), 64'(data));
	endtask

	task automatic test_reset();
		logic [31:0] word;
		@(negedge system_clk);
		word = shown_digits();
		if (word !== 32'h0)
			report_mismatch("reset", 64'h0, 64'(word));
		if ({apb_rsp.pready, apb_rsp.pslverr} !== 2'b00)
			report_mismatch("reset", 64'h0, 64'({apb_rsp.pready, apb_rsp.pslverr}));
	endtask

	task automatic test_command_record();
		logic [17:0] settings [5];
		logic [63:0] rec;
		settings = '{18'h00000, 18'h000FF, 18'h00015, 18'h0002A, 18'h000C3};
		foreach (settings[i])
		begin
			set_switches(settings[i]);
			read_cmd("command", rec);
			if (rec !== expected_cmd(settings[i]))
				report_mismatch("command", expected_cmd(settings[i]), rec);
		end
	endtask

	task automatic test_debounce();
		logic [63:0] rec;
		logic [63:0] expected;
		logic [31:0] hi;
		expected = expected_cmd(18'h0001B);
		set_switches(18'h0001B);
		fork
			begin
				@(posedge system_clk);
				#1;
				sw[SW_ENGINE] = ~sw[SW_ENGINE];		// Glitch one cycle shorter than the filter
				repeat (DEBOUNCE_CYCLES - 1) @(posedge system_clk);
				#1;
				sw[SW_ENGINE] = ~sw[SW_ENGINE];
			end
			begin
				// One read every third cycle, across the glitch and well past it
				for (int n = 0; n < DEBOUNCE_CYCLES + 4; n++)
				begin
					apb_read("debounce", REG_CMD_HI, hi, 1'b0);
					if (hi !== expected[63:32])
						report_mismatch("debounce", 64'(expected[63:32]), 64'(hi));
				end
			end
		join
		read_cmd("debounce", rec);
		if (rec !== expected)
			report_mismatch("debounce", expected, rec);
	endtask

	task automatic test_registers();
		logic [31:0] data;
		logic [63:0] rec;
		for (int w = 0; w < 4; w++)
		begin
			data = $random(seed);
			apb_write("registers", REG_POWER0 + 8'(4 * w), data, 1'b0);
			power_words[w] = (w == 3) ? {16'h0000, data[15:0]} : data;	// Pairs 24 to 27
		end
		data = $random(seed);
		apb_write("registers", REG_SENSOR, data, 1'b0);
		sensor_code = data[3:0];
		data = $random(seed);
		apb_write("registers", REG_POSITION, data, 1'b0);
		x_pos = data[15:0];
		y_pos = data[31:16];
		data = $random(seed);
		apb_write("registers", REG_RX_CHECKSUM, data, 1'b0);
		rx_sum = data[15:0];
		verify_telemetry("registers");
		apb_write("bad access", 8'h1C, $random(seed), 1'b1);	// Hole in the map
		apb_read("bad access", 8'h40, data, 1'b1);
		apb_write("bad access", REG_CMD_LO, 32'hFFFF_FFFF, 1'b1);
		verify_telemetry("bad access");
		read_cmd("bad access", rec);
		if (rec !== expected_cmd(sw))
			report_mismatch("bad access", expected_cmd(sw), rec);
	endtask

	task automatic test_position_view();
		logic [31:0] word;
		set_switches(18'h04000);
		@(negedge system_clk);
		word = shown_digits();
		if (word !== {y_pos, x_pos})
			report_mismatch("position view", 64'({y_pos, x_pos}), 64'(word));
		if (ledr !== {14'h0000, sensor_code})
			report_mismatch("position view", 64'(sensor_code), 64'(ledr));
	endtask

	task automatic test_page_cycle();
		int cycles;
		logic [31:0] word;
		wait_heartbeat(cycles);			// Switch on right after a tick
		set_switches(18'h08000);
		@(negedge system_clk);
		if (ledr !== 18'h3FFFF)
			report_mismatch("page cycle", 64'h3FFFF, 64'(ledr));
		for (int k = 0; k < 10; k++)
		begin
			if (k > 0)
			begin
				wait_heartbeat(cycles);
				repeat (3) @(negedge system_clk);	// Tick, page flop, display flop
			end
			word = shown_digits();
			if (word !== expected_page(k % 9))
				report_mismatch("page cycle", 64'(expected_page(k % 9)), 64'(word));
		end
	endtask

	task automatic test_leds();
		int first;
		int second;
		set_switches(18'h00000);
		@(negedge system_clk);
		if (ledr !== {14'h0000, sensor_code})
			report_mismatch("leds", 64'(sensor_code), 64'(ledr));
		if ((ledg & 9'h1BF) !== 9'h000)
			report_mismatch("leds", 64'h0, 64'(ledg));
		wait_heartbeat(first);
		wait_heartbeat(second);
		if (second + 1 != PAGE_PERIOD)		// One negedge spent on the first sample
			report_mismatch("leds", 64'(PAGE_PERIOD), 64'(second + 1));
	endtask

	initial
	begin
		system_clk = 1'b0;
		rst_n = 1'b0;
		sw = '0;
		apb_req = '0;
		seed = 30;
		value_errors = 0;
		protocol_errors = 0;
		repeat (2) @(posedge system_clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_command_record();
		test_debounce();
		test_registers();
		test_position_view();
		test_page_cycle();
		test_leds();
		$display("Errors: %0d value mismatches, %0d protocol failures",
			value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: logic/ship_console.sv
`timescale 1ns/1ps

module ship_console #(
	parameter int DEBOUNCE_CYCLES = 500000,		// 10 ms at 50 MHz
	parameter int PAGE_PERIOD = 100000000		// 2 s at 50 MHz
) (
	input logic system_clk,
	input logic rst_n,
	input logic [17:0] sw,
	input ship_pkg::apb_req_t apb_req,
	output ship_pkg::apb_rsp_t apb_rsp,
	output logic [7:0][6:0] hex,
	output logic [17:0] ledr,
	output logic [8:0] ledg
);

	import ship_pkg::*;

	logic [17:0] sw_clean;
	logic page_tick;
	logic heartbeat;
	ship_cmd_t cmd;
	telemetry_t telemetry;

	switch_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debouncer (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.sw_raw(sw),
		.sw_clean(sw_clean)
	);

	pulse_timer #(.PERIOD(PAGE_PERIOD)) u_page_timer (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.tick(page_tick),
		.heartbeat(heartbeat)
	);

	telemetry_regs u_regs (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.cmd(cmd),
		.telemetry(telemetry)
	);

	ship_command u_command (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.sw_clean(sw_clean),
		.cmd(cmd)
	);

	status_display u_display (
		.system_clk(system_clk),
		.rst_n(rst_n),
		.sw_clean(sw_clean),
		.page_tick(page_tick),
		.telemetry(telemetry),
		.hex(hex),
		.ledr(ledr)
	);

	assign ledg = {2'b00, heartbeat, 6'b000000};	// Heartbeat on green 6

endmodule

// File: logic/status_display.sv
`timescale 1ns/1ps

module status_display (
	input logic system_clk,
	input logic rst_n,
	input logic [17:0] sw_clean,
	input logic page_tick,
	input ship_pkg::telemetry_t telemetry,
	output logic [7:0][6:0] hex,
	output logic [17:0] ledr
);

	import ship_pkg::*;

	logic [3:0] page;		// 0 banner, 1 to 7 powers, 8 checksum
	logic [4:0] pair_base;		// First pair on this page
	logic [15:0] page_lo;
	logic [15:0] page_hi;
	logic [15:0] disp_lo;		// hex0 to hex3
	logic [15:0] disp_hi;		// hex4 to hex7
	logic [31:0] digits;

	// Active low segments, bit 0 is segment a
	function automatic logic [6:0] seg7(input logic [3:0] nib);
		case (nib)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'hA: seg7 = 7'b0001000;
			4'hB: seg7 = 7'b0000011;
			4'hC: seg7 = 7'b1000110;
			4'hD: seg7 = 7'b0100001;
			4'hE: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	// Page contents
	always_comb
	begin
		pair_base = {page[2:0] - 3'd1, 2'b00};	// 4 pairs per page
		case (page)
			4'd0:
			begin
				page_lo = 16'hABCD;
				page_hi = 16'hDCBA;
			end
			4'd8:
			begin
				page_lo = telemetry.rx_checksum;
				page_hi = telemetry.rx_checksum;
			end
			default:
			begin
				page_lo = {4'h0, telemetry.powers[pair_base], 4'h0,
					telemetry.powers[pair_base + 5'd1]};
				page_hi = {4'h0, telemetry.powers[pair_base + 5'd2], 4'h0,
					telemetry.powers[pair_base + 5'd3]};
			end
		endcase
	end

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			page <= '0;
			disp_lo <= '0;
			disp_hi <= '0;
		end
		else if (sw_clean[SW_PAGE_VIEW])
		begin
			disp_lo <= page_lo;
			disp_hi <= page_hi;
			if (page_tick)
				page <= (page == 4'd8) ? 4'd0 : page + 4'd1;	// Wrap after checksum
		end
		else if (sw_clean[SW_POSITION_VIEW])
		begin
			disp_lo <= telemetry.x_coord;
			disp_hi <= telemetry.y_coord;
		end
	end

	assign digits = {disp_hi, disp_lo};

	always_comb
	begin
		for (int i = 0; i < 8; i++)
			hex[i] = seg7(digits[4*i +: 4]);
	end

	// All on while paging, else the sensor code
	assign ledr = sw_clean[SW_PAGE_VIEW] ? '1 : {14'h0000, telemetry.sensor_detected};

endmodule

// File: logic/ship_command.sv
`timescale 1ns/1ps

module ship_command (
	input logic system_clk,
	input logic rst_n,
	input logic [17:0] sw_clean,
	output ship_pkg::ship_cmd_t cmd
);

	import ship_pkg::*;

	ship_cmd_t cmd_next;

	always_comb
	begin
		cmd_next = '0;
		// Fixed wiring, top slot gets crystal 7
		for (int i = 0; i < 8; i++)
			cmd_next.crystal_hookup[i] = 3'(i);
		cmd_next.engines_on = sw_clean[SW_ENGINE];

		// Engine direction, off means hold position
		if (!sw_clean[SW_DIR_EN])
			cmd_next.engines_dir = MOVE_NONE;
		else if (sw_clean[SW_DIR_RIGHT])
			cmd_next.engines_dir = MOVE_RIGHT;
		else
			cmd_next.engines_dir = MOVE_LEFT;

		// Sensor sweep direction
		if (!sw_clean[SW_SENSOR_EN])
			cmd_next.sensor_dir = MOVE_NONE;
		else if (sw_clean[SW_SENSOR_RIGHT])
			cmd_next.sensor_dir = MOVE_RIGHT;
		else
			cmd_next.sensor_dir = MOVE_LEFT;

		cmd_next.sensor_step = sw_clean[SW_SENSOR_FAST] ? 8'd2 : 8'd1;	// One degree or half
		cmd_next.cannon_fire = sw_clean[SW_FIRE];
		cmd_next.cannon_power = sw_clean[SW_POWER_HIGH] ? 10'd20 : 10'd10;
		cmd_next.tx_checksum = TX_CHECKSUM;
	end

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd <= '0;
			cmd.tx_checksum <= TX_CHECKSUM;	// Valid even before first update
		end
		else
			cmd <= cmd_next;
	end

endmodule

// File: logic/telemetry_regs.sv
`timescale 1ns/1ps

module telemetry_regs (
	input logic system_clk,
	input logic rst_n,
	input ship_pkg::apb_req_t apb_req,
	output ship_pkg::apb_rsp_t apb_rsp,
	input ship_pkg::ship_cmd_t cmd,
	output ship_pkg::telemetry_t telemetry
);

	import ship_pkg::*;

	logic access;			// Second phase of a transfer
	logic mapped;
	logic writable;
	logic wr_en;
	logic [31:0] rd_data;
	logic [63:0] cmd_word;		// Command record, zero padded

	assign access = apb_req.psel & apb_req.penable;
	assign cmd_word = 64'(cmd);

	// Address decode and read mux
	always_comb
	begin
		mapped = 1'b1;
		writable = 1'b1;
		rd_data = '0;
		case (apb_req.paddr)
			REG_POWER0: rd_data = telemetry.powers[7:0];
			REG_POWER1: rd_data = telemetry.powers[15:8];
			REG_POWER2: rd_data = telemetry.powers[23:16];
			REG_POWER3: rd_data = {16'h0000, telemetry.powers[27:24]};
			REG_SENSOR: rd_data = {28'h0, telemetry.sensor_detected};
			REG_POSITION: rd_data = {telemetry.y_coord, telemetry.x_coord};
			REG_RX_CHECKSUM: rd_data = {16'h0000, telemetry.rx_checksum};
			REG_CMD_LO:
			begin
				rd_data = cmd_word[31:0];
				writable = 1'b0;
			end
			REG_CMD_HI:
			begin
				rd_data = cmd_word[63:32];
				writable = 1'b0;
			end
			default:
			begin
				mapped = 1'b0;		// Hole in the map
				writable = 1'b0;
			end
		endcase
	end

	assign wr_en = access & apb_req.pwrite & writable;	// Only mapped words are writable

	// No wait states
	assign apb_rsp.pready = access;
	assign apb_rsp.prdata = rd_data;
	assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & ~writable));

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
			telemetry <= '0;
		else if (wr_en)
		begin
			case (apb_req.paddr)
				REG_POWER0: telemetry.powers[7:0] <= apb_req.pwdata;
				REG_POWER1: telemetry.powers[15:8] <= apb_req.pwdata;
				REG_POWER2: telemetry.powers[23:16] <= apb_req.pwdata;
				REG_POWER3: telemetry.powers[27:24] <= apb_req.pwdata[15:0];	// Upper half dropped
				REG_SENSOR: telemetry.sensor_detected <= apb_req.pwdata[3:0];
				REG_POSITION:
				begin
					telemetry.x_coord <= apb_req.pwdata[15:0];
					telemetry.y_coord <= apb_req.pwdata[31:16];
				end
				REG_RX_CHECKSUM: telemetry.rx_checksum <= apb_req.pwdata[15:0];
				default: ;
			endcase
		end
	end

endmodule

// File: logic/pulse_timer.sv
`timescale 1ns/1ps

module pulse_timer #(
	parameter int PERIOD = 100000000
) (
	input logic system_clk,
	input logic rst_n,
	output logic tick,
	output logic heartbeat
);

	localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

	logic [CNT_W-1:0] count;
	logic wrap;

	assign wrap = (count == CNT_W'(PERIOD - 1));	// Last cycle of the period

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= '0;
			tick <= 1'b0;
			heartbeat <= 1'b0;
		end
		else
		begin
			count <= wrap ? '0 : count + 1'b1;
			tick <= wrap;			// Single cycle strobe
			if (wrap)
				heartbeat <= ~heartbeat;	// Half rate square wave
		end
	end

endmodule

// File: logic/switch_debouncer.sv
`timescale 1ns/1ps

module switch_debouncer #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input logic system_clk,
	input logic rst_n,
	input logic [17:0] sw_raw,
	output logic [17:0] sw_clean
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [17:0] sync_q1;			// First flop, may go metastable
	logic [17:0] sync_q2;			// Safe to use
	logic [CNT_W-1:0] stable_cnt [18];	// Samples that differ from clean

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end
		else
		begin
			sync_q1 <= sw_raw;
			sync_q2 <= sync_q1;
		end
	end

	// One counter per switch, cleared whenever the input agrees again
	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sw_clean <= '0;
			for (int i = 0; i < 18; i++)
				stable_cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 18; i++)
			begin
				if (sync_q2[i] == sw_clean[i])
					stable_cnt[i] <= '0;		// Bounce back, start over
				else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1))
				begin
					sw_clean[i] <= sync_q2[i];	// Held long enough
					stable_cnt[i] <= '0;
				end
				else
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
			end
		end
	end

endmodule

// File: logic/ship_pkg.sv
package ship_pkg;

	localparam int NUM_PAIRS = 28;		// Crystal pairs A_B through G_H

	typedef logic [3:0] power_t;		// Amplification of one pair

	// Telemetry sent back by the game master
	typedef struct packed {
		power_t [NUM_PAIRS-1:0] powers;	// Index 0 is A_B
		logic [3:0] sensor_detected;	// Sensor result code
		logic [15:0] x_coord;
		logic [15:0] y_coord;
		logic [15:0] rx_checksum;	// Checksum expected on next send
	} telemetry_t;

	typedef enum logic [1:0] {
		MOVE_NONE = 2'd0,
		MOVE_RIGHT = 2'd1,
		MOVE_LEFT = 2'd2
	} move_t;

	// Command record for the player's ship
	typedef struct packed {
		logic [7:0][2:0] crystal_hookup;	// Crystal to pair wiring
		logic engines_on;
		move_t engines_dir;
		move_t sensor_dir;
		logic [7:0] sensor_step;	// Half-degree units per sample
		logic cannon_fire;
		logic [9:0] cannon_power;
		logic [15:0] tx_checksum;
	} ship_cmd_t;

	localparam logic [15:0] TX_CHECKSUM = 16'hFAFA;

	typedef struct packed {
		logic [7:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Register map, byte addresses
	localparam logic [7:0] REG_POWER0 = 8'h00;	// Pairs 0 to 7
	localparam logic [7:0] REG_POWER1 = 8'h04;	// Pairs 8 to 15
	localparam logic [7:0] REG_POWER2 = 8'h08;	// Pairs 16 to 23
	localparam logic [7:0] REG_POWER3 = 8'h0C;	// Pairs 24 to 27, low half only
	localparam logic [7:0] REG_SENSOR = 8'h10;
	localparam logic [7:0] REG_POSITION = 8'h14;	// y high, x low
	localparam logic [7:0] REG_RX_CHECKSUM = 8'h18;
	localparam logic [7:0] REG_CMD_LO = 8'h20;	// Read only
	localparam logic [7:0] REG_CMD_HI = 8'h24;	// Read only

	// Slide switch assignment
	localparam int SW_ENGINE = 0;
	localparam int SW_DIR_EN = 1;
	localparam int SW_DIR_RIGHT = 2;
	localparam int SW_SENSOR_EN = 3;
	localparam int SW_SENSOR_RIGHT = 4;
	localparam int SW_SENSOR_FAST = 5;
	localparam int SW_FIRE = 6;
	localparam int SW_POWER_HIGH = 7;
	localparam int SW_POSITION_VIEW = 14;
	localparam int SW_PAGE_VIEW = 15;

endpackage
